// File: design/rv_core_macros.svh
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// data path and address width of the hart
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_REG_COUNT 32

// first fetch address once reset is released
`define RV_RESET_ADDR 32'h0000_0000

// ebreak encoding, matched against the retiring word to raise halt
`define RV_EBREAK 32'h0010_0073

`endif // RV_CORE_MACROS_SVH

// File: design/rv_core_pkg.sv
`include "rv_core_macros.svh"

package rv_core_pkg;

  // major opcodes the core still decodes; anything else retires as a no-op
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  typedef logic [4:0]          reg_addr_t;
  typedef logic [`RV_XLEN-1:0] word_t;

  // decode result handed from ID into EX
  typedef struct packed {
    word_t     pc;
    word_t     inst;
    word_t     op_a;       // rs1 data, or zero for lui
    word_t     op_b;       // rs2 data or the immediate
    word_t     store_data; // rs2 data as the store payload
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_rdata;  // raw reads, only needed again at retire
    word_t     rs2_rdata;
    reg_addr_t rd;         // zero whenever the instruction writes nothing
    alu_op_e   alu_op;
    logic      reg_wen;
    logic      mem_ren;
    logic      mem_wen;
  } id_ex_t;

  typedef struct packed {
    word_t     pc;
    word_t     inst;
    word_t     alu_result; // also the load or store address
    word_t     store_data;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_rdata;
    word_t     rs2_rdata;
    reg_addr_t rd;
    logic      reg_wen;
    logic      mem_ren;
    logic      mem_wen;
  } ex_mem_t;

  // the store side is finished by the time an instruction reaches writeback
  typedef struct packed {
    word_t     pc;
    word_t     inst;
    word_t     alu_result;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_rdata;
    word_t     rs2_rdata;
    reg_addr_t rd;
    logic      reg_wen;
    logic      mem_ren;
  } mem_wb_t;

  typedef struct packed {
    word_t addr;  // word aligned, two low bits always zero
    logic  ren;
    logic  wen;   // never set together with ren
    word_t wdata;
  } dmem_req_t;

  typedef struct packed {
    logic      valid;
    word_t     inst;
    word_t     pc;
    logic      halt;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_rdata;
    word_t     rs2_rdata;
    reg_addr_t rd_addr;
    word_t     rd_wdata;
  } retire_t;

endpackage

// File: design/pipe_stage_reg.sv
`timescale 1ns/1ps

// one pipeline boundary: a valid flag plus whatever payload the stage carries
module pipe_stage_reg #(
  parameter type T = logic
) (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_valid,
  input  T     i_data,
  output logic o_valid,
  output T     o_data
);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid; // a bubble simply shows up here as a cleared valid
    end
  end

  // the payload only moves with a real instruction, bubbles leave it untouched
  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_data <= i_data;
    end
  end

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module fetch_unit (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_stall,
  input  rv_core_pkg::word_t i_imem_rdata,
  output rv_core_pkg::word_t o_imem_raddr,
  output rv_core_pkg::word_t o_pc,
  output rv_core_pkg::word_t o_inst,
  output logic               o_valid
);

  rv_core_pkg::word_t pc_q;    // next sequential fetch address
  rv_core_pkg::word_t id_pc_q; // address of the word now sitting in IF/ID
  logic               valid_q;

  // on a stall the address of the held word goes out again, so the
  // synchronous memory hands back the same instruction next cycle
  assign o_imem_raddr = i_stall ? id_pc_q : pc_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q    <= `RV_RESET_ADDR;
      id_pc_q <= `RV_RESET_ADDR;
      valid_q <= 1'b0; // nothing has been fetched yet
    end else if (!i_stall) begin
      pc_q    <= pc_q + `RV_XLEN'd4;
      id_pc_q <= pc_q;
      valid_q <= 1'b1; // first word lands one cycle after reset releases
    end
  end

  // the memory output register doubles as the IF/ID instruction register
  assign o_inst  = i_imem_rdata;
  assign o_pc    = id_pc_q;
  assign o_valid = valid_q;

endmodule

// File: design/inst_decoder.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module inst_decoder (
  input  rv_core_pkg::word_t     i_inst,
  input  rv_core_pkg::word_t     i_pc,
  input  rv_core_pkg::word_t     i_rs1_rdata,
  input  rv_core_pkg::word_t     i_rs2_rdata,
  output rv_core_pkg::reg_addr_t o_rs1_raddr,
  output rv_core_pkg::reg_addr_t o_rs2_raddr,
  output logic                   o_uses_rs1,
  output logic                   o_uses_rs2,
  output rv_core_pkg::id_ex_t    o_id_ex
);

  logic [2:0]           funct3;
  logic [6:0]           funct7;
  rv_core_pkg::word_t   imm_i;
  rv_core_pkg::word_t   imm_s;
  rv_core_pkg::word_t   imm_u;
  rv_core_pkg::word_t   imm;
  logic                 use_imm;
  logic                 is_lui;
  logic                 reg_wen;
  logic                 mem_ren;
  logic                 mem_wen;
  rv_core_pkg::alu_op_e alu_op;

  // shared by register and immediate forms; alt picks sub or sra
  function automatic rv_core_pkg::alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_from_funct = alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      3'b001:  alu_from_funct = rv_core_pkg::ALU_SLL;
      3'b010:  alu_from_funct = rv_core_pkg::ALU_SLT;
      3'b011:  alu_from_funct = rv_core_pkg::ALU_SLTU;
      3'b100:  alu_from_funct = rv_core_pkg::ALU_XOR;
      3'b101:  alu_from_funct = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      3'b110:  alu_from_funct = rv_core_pkg::ALU_OR;
      default: alu_from_funct = rv_core_pkg::ALU_AND;
    endcase
  endfunction

  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_u = {i_inst[31:12], 12'b0};

  always_comb begin
    o_uses_rs1 = 1'b0; // default is a word that does nothing at all
    o_uses_rs2 = 1'b0;
    use_imm    = 1'b0;
    is_lui     = 1'b0;
    reg_wen    = 1'b0;
    mem_ren    = 1'b0;
    mem_wen    = 1'b0;
    imm        = imm_i;
    alu_op     = rv_core_pkg::ALU_ADD; // loads, stores and lui all add
    case (rv_core_pkg::opcode_e'(i_inst[6:0]))
      rv_core_pkg::OP: begin
        // only funct7 of zero, or 0100000 on add and shift right, is legal
        if (funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101})) begin
          o_uses_rs1 = 1'b1;
          o_uses_rs2 = 1'b1;
          reg_wen    = 1'b1;
          alu_op     = alu_from_funct(funct3, funct7[5]);
        end
      end
      rv_core_pkg::OP_IMM: begin
        // shift immediates reuse the funct7 field, the rest is free immediate
        if ((funct3 != 3'b001 || funct7 == 7'b0) &&
            (funct3 != 3'b101 || funct7 == 7'b0 || funct7 == 7'b0100000)) begin
          o_uses_rs1 = 1'b1;
          use_imm    = 1'b1;
          reg_wen    = 1'b1;
          alu_op     = alu_from_funct(funct3, funct3 == 3'b101 && funct7[5]);
        end
      end
      rv_core_pkg::LUI: begin
        is_lui  = 1'b1;
        use_imm = 1'b1;
        imm     = imm_u;
        reg_wen = 1'b1;
      end
      rv_core_pkg::LOAD: begin
        if (funct3 == 3'b010) begin // lw only
          o_uses_rs1 = 1'b1;
          use_imm    = 1'b1;
          reg_wen    = 1'b1;
          mem_ren    = 1'b1;
        end
      end
      rv_core_pkg::STORE: begin
        if (funct3 == 3'b010) begin // sw only
          o_uses_rs1 = 1'b1;
          o_uses_rs2 = 1'b1;
          use_imm    = 1'b1;
          imm        = imm_s;
          mem_wen    = 1'b1;
        end
      end
      rv_core_pkg::SYSTEM: ; // ebreak is spotted at retire and has no side effect here
      default: ;
    endcase
  end

  // unused source slots read as x0 so the reported data is zero as well
  assign o_rs1_raddr = o_uses_rs1 ? i_inst[19:15] : '0;
  assign o_rs2_raddr = o_uses_rs2 ? i_inst[24:20] : '0;

  always_comb begin
    o_id_ex            = '0;
    o_id_ex.pc         = i_pc;
    o_id_ex.inst       = i_inst;
    o_id_ex.op_a       = is_lui ? '0 : i_rs1_rdata;
    o_id_ex.op_b       = use_imm ? imm : i_rs2_rdata;
    o_id_ex.store_data = i_rs2_rdata;
    o_id_ex.rs1_addr   = o_rs1_raddr;
    o_id_ex.rs2_addr   = o_rs2_raddr;
    o_id_ex.rs1_rdata  = i_rs1_rdata;
    o_id_ex.rs2_rdata  = i_rs2_rdata;
    o_id_ex.rd         = reg_wen ? i_inst[11:7] : '0; // stores and no-ops report x0
    o_id_ex.alu_op     = alu_op;
    o_id_ex.reg_wen    = reg_wen;
    o_id_ex.mem_ren    = mem_ren;
    o_id_ex.mem_wen    = mem_wen;
  end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module reg_file (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  rv_core_pkg::reg_addr_t i_rs1_raddr,
  input  rv_core_pkg::reg_addr_t i_rs2_raddr,
  input  rv_core_pkg::reg_addr_t i_rd_waddr,
  input  logic                   i_rd_wen,
  input  rv_core_pkg::word_t     i_rd_wdata,
  output rv_core_pkg::word_t     o_rs1_rdata,
  output rv_core_pkg::word_t     o_rs2_rdata
);

  rv_core_pkg::word_t regs [1:`RV_REG_COUNT-1]; // x0 has no storage
  logic               wr_en;

  assign wr_en = i_rd_wen && (i_rd_waddr != '0); // writes to x0 vanish

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[i_rd_waddr] <= i_rd_wdata;
    end
  end

  // writeback in the same cycle is forwarded, which is why the hazard
  // unit never has to look at the WB stage
  assign o_rs1_rdata = (i_rs1_raddr == '0) ? '0 :
                       (wr_en && i_rd_waddr == i_rs1_raddr) ? i_rd_wdata :
                       regs[i_rs1_raddr];
  assign o_rs2_rdata = (i_rs2_raddr == '0) ? '0 :
                       (wr_en && i_rd_waddr == i_rs2_raddr) ? i_rd_wdata :
                       regs[i_rs2_raddr];

endmodule

// File: design/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
  input  logic                   i_if_valid,
  input  rv_core_pkg::reg_addr_t i_rs1_raddr,
  input  rv_core_pkg::reg_addr_t i_rs2_raddr,
  input  logic                   i_uses_rs1,
  input  logic                   i_uses_rs2,
  input  logic                   i_ex_valid,
  input  rv_core_pkg::reg_addr_t i_ex_rd,
  input  logic                   i_ex_wen,
  input  logic                   i_mem_valid,
  input  rv_core_pkg::reg_addr_t i_mem_rd,
  input  logic                   i_mem_wen,
  output logic                   o_stall
);

  logic ex_hit;
  logic mem_hit;

  // x0 never creates a dependency; WB is covered by the register file bypass
  assign ex_hit  = i_ex_valid && i_ex_wen && (i_ex_rd != '0) &&
                   ((i_uses_rs1 && i_rs1_raddr == i_ex_rd) ||
                    (i_uses_rs2 && i_rs2_raddr == i_ex_rd));
  assign mem_hit = i_mem_valid && i_mem_wen && (i_mem_rd != '0) &&
                   ((i_uses_rs1 && i_rs1_raddr == i_mem_rd) ||
                    (i_uses_rs2 && i_rs2_raddr == i_mem_rd));

  assign o_stall = i_if_valid && (ex_hit || mem_hit);

endmodule

// File: design/alu.sv
`timescale 1ns/1ps

module alu (
  input  rv_core_pkg::alu_op_e i_op,
  input  rv_core_pkg::word_t   i_a,
  input  rv_core_pkg::word_t   i_b,
  output rv_core_pkg::word_t   o_result
);

  logic [4:0] shamt;

  assign shamt = i_b[4:0]; // only the low five bits count for rv32 shifts

  always_comb begin
    case (i_op)
      rv_core_pkg::ALU_ADD:  o_result = i_a + i_b; // also the lw and sw address
      rv_core_pkg::ALU_SUB:  o_result = i_a - i_b;
      rv_core_pkg::ALU_AND:  o_result = i_a & i_b;
      rv_core_pkg::ALU_OR:   o_result = i_a | i_b;
      rv_core_pkg::ALU_XOR:  o_result = i_a ^ i_b;
      rv_core_pkg::ALU_SLT:  o_result = rv_core_pkg::word_t'($signed(i_a) < $signed(i_b));
      rv_core_pkg::ALU_SLTU: o_result = rv_core_pkg::word_t'(i_a < i_b);
      rv_core_pkg::ALU_SLL:  o_result = i_a << shamt;
      rv_core_pkg::ALU_SRL:  o_result = i_a >> shamt;
      rv_core_pkg::ALU_SRA:  o_result = $signed(i_a) >>> shamt;
      default:               o_result = '0;
    endcase
  end

endmodule

// File: design/rv_core.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_core (
  input  logic                   i_clk,
  input  logic                   i_rst,
  output rv_core_pkg::word_t     o_imem_raddr,
  input  rv_core_pkg::word_t     i_imem_rdata,
  output rv_core_pkg::dmem_req_t o_dmem_req,
  input  rv_core_pkg::word_t     i_dmem_rdata,
  output rv_core_pkg::retire_t   o_retire
);

  rv_core_pkg::word_t     if_pc;
  rv_core_pkg::word_t     if_inst;
  logic                   if_valid;
  logic                   stall;
  rv_core_pkg::reg_addr_t rs1_raddr;
  rv_core_pkg::reg_addr_t rs2_raddr;
  rv_core_pkg::word_t     rs1_rdata;
  rv_core_pkg::word_t     rs2_rdata;
  logic                   uses_rs1;
  logic                   uses_rs2;
  rv_core_pkg::id_ex_t    id_ex_d;
  rv_core_pkg::id_ex_t    id_ex_q;
  logic                   ex_valid;
  rv_core_pkg::word_t     alu_result;
  rv_core_pkg::ex_mem_t   ex_mem_d;
  rv_core_pkg::ex_mem_t   ex_mem_q;
  logic                   mem_valid;
  rv_core_pkg::mem_wb_t   mem_wb_d;
  rv_core_pkg::mem_wb_t   mem_wb_q;
  logic                   wb_valid;
  rv_core_pkg::word_t     wb_data;
  logic                   rf_wen;

  // IF: pc plus the IF/ID register, held in place while stalled
  fetch_unit u_fetch (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_stall      (stall),
    .i_imem_rdata (i_imem_rdata),
    .o_imem_raddr (o_imem_raddr),
    .o_pc         (if_pc),
    .o_inst       (if_inst),
    .o_valid      (if_valid)
  );

  // ID
  inst_decoder u_decoder (
    .i_inst      (if_inst),
    .i_pc        (if_pc),
    .i_rs1_rdata (rs1_rdata),
    .i_rs2_rdata (rs2_rdata),
    .o_rs1_raddr (rs1_raddr),
    .o_rs2_raddr (rs2_raddr),
    .o_uses_rs1  (uses_rs1),
    .o_uses_rs2  (uses_rs2),
    .o_id_ex     (id_ex_d)
  );

  reg_file u_reg_file (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rs1_raddr (rs1_raddr),
    .i_rs2_raddr (rs2_raddr),
    .i_rd_waddr  (mem_wb_q.rd),
    .i_rd_wen    (rf_wen),
    .i_rd_wdata  (wb_data),
    .o_rs1_rdata (rs1_rdata),
    .o_rs2_rdata (rs2_rdata)
  );

  hazard_unit u_hazard (
    .i_if_valid  (if_valid),
    .i_rs1_raddr (rs1_raddr),
    .i_rs2_raddr (rs2_raddr),
    .i_uses_rs1  (uses_rs1),
    .i_uses_rs2  (uses_rs2),
    .i_ex_valid  (ex_valid),
    .i_ex_rd     (id_ex_q.rd),
    .i_ex_wen    (id_ex_q.reg_wen),
    .i_mem_valid (mem_valid),
    .i_mem_rd    (ex_mem_q.rd),
    .i_mem_wen   (ex_mem_q.reg_wen),
    .o_stall     (stall)
  );

  // a stalled decode goes into EX as a bubble
  pipe_stage_reg #(.T(rv_core_pkg::id_ex_t)) u_id_ex (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (if_valid && !stall),
    .i_data  (id_ex_d),
    .o_valid (ex_valid),
    .o_data  (id_ex_q)
  );

  // EX
  alu u_alu (
    .i_op     (id_ex_q.alu_op),
    .i_a      (id_ex_q.op_a),
    .i_b      (id_ex_q.op_b),
    .o_result (alu_result)
  );

  always_comb begin
    ex_mem_d            = '0;
    ex_mem_d.pc         = id_ex_q.pc;
    ex_mem_d.inst       = id_ex_q.inst;
    ex_mem_d.alu_result = alu_result;
    ex_mem_d.store_data = id_ex_q.store_data;
    ex_mem_d.rs1_addr   = id_ex_q.rs1_addr;
    ex_mem_d.rs2_addr   = id_ex_q.rs2_addr;
    ex_mem_d.rs1_rdata  = id_ex_q.rs1_rdata;
    ex_mem_d.rs2_rdata  = id_ex_q.rs2_rdata;
    ex_mem_d.rd         = id_ex_q.rd;
    ex_mem_d.reg_wen    = id_ex_q.reg_wen;
    ex_mem_d.mem_ren    = id_ex_q.mem_ren;
    ex_mem_d.mem_wen    = id_ex_q.mem_wen;
  end

  pipe_stage_reg #(.T(rv_core_pkg::ex_mem_t)) u_ex_mem (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (ex_valid),
    .i_data  (ex_mem_d),
    .o_valid (mem_valid),
    .o_data  (ex_mem_q)
  );

  // MEM: word accesses only, so the byte offset is dropped
  always_comb begin
    o_dmem_req.addr  = {ex_mem_q.alu_result[`RV_XLEN-1:2], 2'b00};
    o_dmem_req.ren   = mem_valid && ex_mem_q.mem_ren;
    o_dmem_req.wen   = mem_valid && ex_mem_q.mem_wen; // stale payload behind a bubble stays quiet
    o_dmem_req.wdata = ex_mem_q.store_data;
  end

  always_comb begin
    mem_wb_d            = '0;
    mem_wb_d.pc         = ex_mem_q.pc;
    mem_wb_d.inst       = ex_mem_q.inst;
    mem_wb_d.alu_result = ex_mem_q.alu_result;
    mem_wb_d.rs1_addr   = ex_mem_q.rs1_addr;
    mem_wb_d.rs2_addr   = ex_mem_q.rs2_addr;
    mem_wb_d.rs1_rdata  = ex_mem_q.rs1_rdata;
    mem_wb_d.rs2_rdata  = ex_mem_q.rs2_rdata;
    mem_wb_d.rd         = ex_mem_q.rd;
    mem_wb_d.reg_wen    = ex_mem_q.reg_wen;
    mem_wb_d.mem_ren    = ex_mem_q.mem_ren;
  end

  pipe_stage_reg #(.T(rv_core_pkg::mem_wb_t)) u_mem_wb (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (mem_valid),
    .i_data  (mem_wb_d),
    .o_valid (wb_valid),
    .o_data  (mem_wb_q)
  );

  // WB: load data shows up from the memory exactly in this cycle
  assign wb_data = mem_wb_q.mem_ren ? i_dmem_rdata : mem_wb_q.alu_result;
  assign rf_wen  = wb_valid && mem_wb_q.reg_wen;

  always_comb begin
    o_retire.valid     = wb_valid;
    o_retire.inst      = mem_wb_q.inst;
    o_retire.pc        = mem_wb_q.pc;
    o_retire.halt      = wb_valid && (mem_wb_q.inst == `RV_EBREAK);
    o_retire.rs1_addr  = mem_wb_q.rs1_addr;
    o_retire.rs2_addr  = mem_wb_q.rs2_addr;
    o_retire.rs1_rdata = mem_wb_q.rs1_rdata;
    o_retire.rs2_rdata = mem_wb_q.rs2_rdata;
    o_retire.rd_addr   = mem_wb_q.rd;
    o_retire.rd_wdata  = wb_data;
  end

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps

// free-running 40 ns clock, reset held high across the first five rising edges
module tb_clk_gen (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #20 o_clk = ~o_clk; // half of the 40 ns period
  end

  initial begin
    o_rst = 1'b1;
    repeat (5) @(posedge o_clk);
    #1 o_rst = 1'b0; // released just after the edge, like every other DUT input
  end

endmodule

// File: verification/tb_iss_model.svh
`ifndef TB_ISS_MODEL_SVH
`define TB_ISS_MODEL_SVH

// architectural state of the in-order model, x0 is never written
rv_core_pkg::word_t     mdl_regs [`RV_REG_COUNT];
rv_core_pkg::word_t     mdl_mem  [DMEM_WORDS];
rv_core_pkg::retire_t   exp_retire [$]; // one record per instruction, in program order
rv_core_pkg::dmem_req_t exp_stores [$];

// multiplicative hash so that every index bit changes the word
function automatic rv_core_pkg::word_t data_fill(input int unsigned idx);
  return (idx * 32'h9e37_79b9) ^ 32'hc3a5_0f1e;
endfunction

// words past the program carry opcode 7'h7f, which decodes to nothing
function automatic rv_core_pkg::word_t imem_fill(input int unsigned idx);
  rv_core_pkg::word_t w;
  w = (idx * 32'h85eb_ca6b) ^ 32'h27d4_eb2f;
  return {w[31:7], 7'b1111111};
endfunction

function automatic rv_core_pkg::word_t model_alu(input logic [2:0] f3, input logic alt,
                                                 input rv_core_pkg::word_t a,
                                                 input rv_core_pkg::word_t b);
  rv_core_pkg::word_t res;
  case (f3)
    3'b000: res = alt ? a - b : a + b;
    3'b001: res = a << b[4:0];
    3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011: res = (a < b) ? 32'd1 : 32'd0;
    3'b100: res = a ^ b;
    3'b101: begin
      if (alt) begin
        res = $signed(a) >>> b[4:0]; // kept apart from the logical shift on purpose of sign
      end else begin
        res = a >> b[4:0];
      end
    end
    3'b110: res = a | b;
    default: res = a & b;
  endcase
  return res;
endfunction

// registers come from x0..x7 only, so back-to-back dependencies are frequent
function automatic rv_core_pkg::word_t random_inst();
  int unsigned kind;
  logic [2:0]  f3;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic        alt;
  logic [11:0] imm;
  logic [19:0] upper;
  logic [7:0]  widx;
  kind  = $urandom_range(9, 0);
  f3    = 3'($urandom_range(7, 0));
  rd    = 5'($urandom_range(7, 0));
  rs1   = 5'($urandom_range(7, 0));
  rs2   = 5'($urandom_range(7, 0));
  alt   = 1'($urandom_range(1, 0));
  imm   = 12'($urandom_range(4095, 0));
  upper = 20'($urandom());
  widx  = 8'($urandom_range(DMEM_WORDS - 1, 0)); // word index inside the data region
  if (kind < 3) begin
    // register form, sub and sra only where funct3 allows them
    return {(alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000,
            rs2, rs1, f3, rd, 7'b0110011};
  end
  if (kind < 6) begin
    if (f3 == 3'b001) begin
      imm[11:5] = 7'b0000000; // slli
    end
    if (f3 == 3'b101) begin
      imm[11:5] = alt ? 7'b0100000 : 7'b0000000; // srai or srli
    end
    return {imm, rs1, f3, rd, 7'b0010011};
  end
  if (kind == 6) begin
    return {upper, rd, 7'b0110111}; // lui
  end
  imm = {2'b00, widx, 2'b00}; // x0 based, so the immediate is the byte address
  if (kind < 9) begin
    return {imm, 5'd0, 3'b010, rd, 7'b0000011}; // lw
  end
  return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011}; // sw
endfunction

// executes one word and queues what the DUT should report for it
task automatic model_step(input rv_core_pkg::word_t pc, input rv_core_pkg::word_t inst);
  rv_core_pkg::retire_t   rec;
  rv_core_pkg::dmem_req_t st;
  rv_core_pkg::word_t     imm_i;
  rv_core_pkg::word_t     imm_s;
  rv_core_pkg::word_t     addr;
  rv_core_pkg::word_t     result;
  logic [2:0]             f3;
  logic                   writes;
  f3       = inst[14:12];
  imm_i    = {{20{inst[31]}}, inst[31:20]};
  imm_s    = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  rec      = '0;
  rec.valid = 1'b1;
  rec.pc    = pc;
  rec.inst  = inst;
  rec.halt  = (inst == 32'h0010_0073); // ebreak
  writes   = 1'b1;
  result   = '0;
  case (inst[6:0])
    7'b0110011: begin
      rec.rs1_addr = inst[19:15];
      rec.rs2_addr = inst[24:20];
      result = model_alu(f3, inst[30], mdl_regs[inst[19:15]], mdl_regs[inst[24:20]]);
    end
    7'b0010011: begin
      rec.rs1_addr = inst[19:15];
      result = model_alu(f3, f3 == 3'b101 && inst[30], mdl_regs[inst[19:15]], imm_i);
    end
    7'b0110111: result = {inst[31:12], 12'b0};
    7'b0000011: begin
      rec.rs1_addr = inst[19:15];
      addr   = mdl_regs[inst[19:15]] + imm_i;
      result = mdl_mem[addr[9:2]];
    end
    7'b0100011: begin
      rec.rs1_addr = inst[19:15];
      rec.rs2_addr = inst[24:20];
      writes   = 1'b0;
      addr     = mdl_regs[inst[19:15]] + imm_s;
      st       = '0;
      st.addr  = {addr[31:2], 2'b00};
      st.wen   = 1'b1;
      st.wdata = mdl_regs[inst[24:20]];
      exp_stores.push_back(st);
      mdl_mem[addr[9:2]] = st.wdata;
    end
    default: writes = 1'b0; // ebreak and undecodable words change nothing
  endcase
  // source data is the state before this instruction
  rec.rs1_rdata = mdl_regs[rec.rs1_addr];
  rec.rs2_rdata = mdl_regs[rec.rs2_addr];
  if (writes) begin
    rec.rd_addr  = inst[11:7];
    rec.rd_wdata = result;
    if (inst[11:7] != 5'd0) begin
      mdl_regs[inst[11:7]] = result;
    end
  end
  exp_retire.push_back(rec);
endtask

// fills both memories, writes the program and runs the model over all of it
task automatic build_program();
  for (int i = 0; i < IMEM_WORDS; i++) begin
    imem[i] = imem_fill(i);
  end
  for (int i = 0; i < DMEM_WORDS; i++) begin
    dmem[i]    = data_fill(i);
    mdl_mem[i] = data_fill(i);
  end
  for (int i = 0; i < `RV_REG_COUNT; i++) begin
    mdl_regs[i] = '0;
  end
  for (int i = 0; i < PROG_LEN - 1; i++) begin
    imem[i] = random_inst();
  end
  imem[PROG_LEN-1] = 32'h0010_0073; // program ends in ebreak
  for (int i = 0; i < PROG_LEN; i++) begin
    model_step(32'(i) << 2, imem[i]);
  end
endtask

`endif // TB_ISS_MODEL_SVH

// File: verification/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_core_tb;

  localparam int PROG_LEN      = 200; // ebreak included
  localparam int IMEM_WORDS    = 512;
  localparam int DMEM_WORDS    = 256;
  localparam int RESET_TIMEOUT = 20;  // cycles
  localparam int RUN_TIMEOUT   = 3000;

  logic                   clk;
  logic                   rst;
  rv_core_pkg::word_t     imem_raddr;
  rv_core_pkg::word_t     imem_rdata;
  rv_core_pkg::dmem_req_t dmem_req;
  rv_core_pkg::word_t     dmem_rdata;
  rv_core_pkg::retire_t   retire;
  rv_core_pkg::word_t     imem [IMEM_WORDS];
  rv_core_pkg::word_t     dmem [DMEM_WORDS];
  int                     value_errors = 0;
  int                     other_errors = 0;
  int                     retire_count = 0;
  logic                   halt_seen = 1'b0;

  `include "tb_iss_model.svh"

  tb_clk_gen u_clk_gen (
    .o_clk (clk),
    .o_rst (rst)
  );

  rv_core UUT (
    .i_clk        (clk),
    .i_rst        (rst),
    .o_imem_raddr (imem_raddr),
    .i_imem_rdata (imem_rdata),
    .o_dmem_req   (dmem_req),
    .i_dmem_rdata (dmem_rdata),
    .o_retire     (retire)
  );

  // instruction memory, the word follows its address by one clock
  always @(posedge clk) begin
    rv_core_pkg::word_t addr;
    addr = imem_raddr; // sampled before the DUT registers update
    #1;
    imem_rdata = imem[addr[10:2]];
  end

  // data memory, same one clock read latency; stores land at the edge
  always @(posedge clk) begin
    rv_core_pkg::dmem_req_t req;
    req = dmem_req;
    #1;
    if (req.wen === 1'b1) begin
      dmem[req.addr[9:2]] = req.wdata;
    end
    if (req.ren === 1'b1) begin
      dmem_rdata = dmem[req.addr[9:2]];
    end
  end

  task automatic check_word(input string name, input rv_core_pkg::word_t expected,
                            input rv_core_pkg::word_t actual);
    assert (actual === expected) else begin
      value_errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_retire();
    rv_core_pkg::retire_t want;
    string                tag;
    assert (exp_retire.size() != 0) else begin
      other_errors++;
      $display("an instruction retired after the whole program, pc %h", retire.pc);
    end
    if (exp_retire.size() != 0) begin
      want = exp_retire.pop_front();
      retire_count++;
      tag  = $sformatf("retire %0d", retire_count);
      check_word({tag, " pc"}, want.pc, retire.pc);
      check_word({tag, " inst"}, want.inst, retire.inst);
      check_word({tag, " halt"}, 32'(want.halt), 32'(retire.halt));
      check_word({tag, " rs1 addr"}, 32'(want.rs1_addr), 32'(retire.rs1_addr));
      check_word({tag, " rs2 addr"}, 32'(want.rs2_addr), 32'(retire.rs2_addr));
      check_word({tag, " rs1 data"}, want.rs1_rdata, retire.rs1_rdata);
      check_word({tag, " rs2 data"}, want.rs2_rdata, retire.rs2_rdata);
      check_word({tag, " rd addr"}, 32'(want.rd_addr), 32'(retire.rd_addr));
      if (want.rd_addr != 5'd0) begin
        check_word({tag, " rd data"}, want.rd_wdata, retire.rd_wdata); // covers lw data too
      end
    end
    if (retire.halt === 1'b1) begin
      halt_seen = 1'b1;
    end
  endtask

  task automatic check_store();
    rv_core_pkg::dmem_req_t want;
    assert (!(dmem_req.ren === 1'b1 && dmem_req.wen === 1'b1)) else begin
      other_errors++;
      $display("data request has read and write enable set in the same cycle");
    end
    if (dmem_req.wen === 1'b1) begin
      assert (exp_stores.size() != 0) else begin
        other_errors++;
        $display("unexpected store to address %h", dmem_req.addr);
      end
      if (exp_stores.size() != 0) begin
        want = exp_stores.pop_front();
        check_word("store address", want.addr, dmem_req.addr);
        check_word("store data", want.wdata, dmem_req.wdata);
      end
    end
  endtask

  // monitor, outputs are read at the edge where they are settled
  always @(posedge clk) begin
    if (rst === 1'b0 && !halt_seen) begin
      check_store();
      if (retire.valid === 1'b1) begin
        check_retire();
      end
    end
  end

  initial begin
    int cycles;
    imem_rdata = '0;
    dmem_rdata = '0;
    void'($urandom(32'hb9b81479));
    build_program();

    // reset window, the first edge still sees unreset flops
    cycles = 0;
    while (rst !== 1'b0 && cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      if (cycles > 1 && rst === 1'b1) begin
        assert (retire.valid === 1'b0 && dmem_req.ren === 1'b0 && dmem_req.wen === 1'b0)
        else begin
          other_errors++;
          $display("retire valid or a data memory enable is active during reset");
        end
      end
    end
    assert (rst === 1'b0) else begin
      other_errors++;
      $display("reset never released within %0d cycles", RESET_TIMEOUT);
    end

    // this edge is the first one out of reset, the address it sees is the first fetch
    check_word("first fetch address", 32'h0000_0000, imem_raddr);

    cycles = 0;
    while (!halt_seen && cycles < RUN_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    assert (halt_seen) else begin
      other_errors++;
      $display("no halt retired within %0d cycles", RUN_TIMEOUT);
    end
    check_word("retire count", PROG_LEN, retire_count);
    check_word("stores left over", 0, exp_stores.size());

    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: rv_core.f
+incdir+design
+incdir+verification
design/rv_core_pkg.sv
design/pipe_stage_reg.sv
design/fetch_unit.sv
design/inst_decoder.sv
design/reg_file.sv
design/hazard_unit.sv
design/alu.sv
design/rv_core.sv
verification/tb_clk_gen.sv
verification/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - design

sources:
  - design/rv_core_pkg.sv
  - design/pipe_stage_reg.sv
  - design/fetch_unit.sv
  - design/inst_decoder.sv
  - design/reg_file.sv
  - design/hazard_unit.sv
  - design/alu.sv
  - design/rv_core.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_clk_gen.sv
      - verification/rv_core_tb.sv
